//--- hdl/fetch_cfg.svh
`ifndef FETCH_CFG_SVH
`define FETCH_CFG_SVH

// datapath and address width
`define XLEN            32

// first fetch address out of reset
`define RESET_PC        32'h1eceb000

// btb indexed by pc[5:2], 16 entries
`define BTB_IDX_BITS    4

// fetch queue geometry
`define FQ_DEPTH        8
`define FQ_PTR_BITS     3

`endif

//--- hdl/fetch_pkg.sv
`include "fetch_cfg.svh"

package fetch_pkg;

    // major opcodes predecode cares about, plus two plain ones
    typedef enum logic [6:0] {
        op_jal  = 7'b1101111,
        op_jalr = 7'b1100111,
        op_br   = 7'b1100011,
        op_imm  = 7'b0010011,   // filler alu ops
        op_reg  = 7'b0110011
    } opcode_e;

    typedef enum logic [1:0] {
        st_idle = 2'b00,    // free to issue
        st_wait = 2'b01,    // request outstanding
        st_drop = 2'b10     // in-flight response gets thrown away
    } fetch_state_e;

    // one fetch queue slot, fields move together
    typedef struct packed {
        logic [`XLEN-1:0]   inst;
        logic [`XLEN-1:0]   pc;
        logic               pred_taken;
        logic [`XLEN-1:0]   pred_target;    // predicted next pc
    } fetch_entry_t;

endpackage

//--- hdl/btb.sv
`timescale 1ns/100ps
`include "fetch_cfg.svh"

module btb (
    input  logic                clk,
    input  logic                rst,

    // lookup, combinational
    input  logic [`XLEN-1:0]    rd_pc_i,
    output logic                hit_o,
    output logic [`XLEN-1:0]    target_o,

    // update from the back end
    input  logic                we_i,
    input  logic [`XLEN-1:0]    wr_pc_i,
    input  logic [`XLEN-1:0]    wr_target_i
);

    localparam int BTB_ENTRIES = 1 << `BTB_IDX_BITS;

    logic [`XLEN-1:0]           target_mem [BTB_ENTRIES];
    logic [BTB_ENTRIES-1:0]     valid_q;
    logic [`BTB_IDX_BITS-1:0]   rd_idx;
    logic [`BTB_IDX_BITS-1:0]   wr_idx;

    // word aligned pcs, skip bits [1:0]
    assign rd_idx = rd_pc_i[`BTB_IDX_BITS+1:2];
    assign wr_idx = wr_pc_i[`BTB_IDX_BITS+1:2];

    assign hit_o    = valid_q[rd_idx];
    assign target_o = target_mem[rd_idx];

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= '0;
        end else if (we_i) begin
            valid_q[wr_idx] <= 1'b1;
        end
    end

    // target visible to lookups from the next cycle
    always_ff @(posedge clk) begin
        if (we_i) begin
            target_mem[wr_idx] <= wr_target_i;
        end
    end

endmodule : btb

//--- hdl/fetch_queue.sv
`timescale 1ns/100ps
`include "fetch_cfg.svh"

module fetch_queue
    import fetch_pkg::*;
(
    input  logic            clk,
    input  logic            rst,

    input  logic            flush_i,

    input  logic            enq_i,
    input  fetch_entry_t    enq_entry_i,

    input  logic            deq_i,
    output fetch_entry_t    head_o,

    output logic            full_o,
    output logic            empty_o
);

    localparam logic [`FQ_PTR_BITS-1:0] PTR_LAST = `FQ_PTR_BITS'(`FQ_DEPTH - 1);
    localparam logic [`FQ_PTR_BITS:0]   CNT_FULL = (`FQ_PTR_BITS + 1)'(`FQ_DEPTH);

    fetch_entry_t               q_mem [`FQ_DEPTH];
    logic [`FQ_PTR_BITS-1:0]    wr_ptr_q;
    logic [`FQ_PTR_BITS-1:0]    rd_ptr_q;
    logic [`FQ_PTR_BITS:0]      count_q;   // one extra bit for full
    logic                       do_enq;
    logic                       do_deq;

    assign full_o  = (count_q == CNT_FULL);
    assign empty_o = (count_q == '0);
    assign head_o  = q_mem[rd_ptr_q];

    // dequeue on empty is a no-op
    assign do_deq = deq_i && !empty_o;
    // a full queue still takes a write when the head leaves
    assign do_enq = enq_i && (!full_o || do_deq);

    always_ff @(posedge clk) begin
        if (rst || flush_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (do_enq) begin
                wr_ptr_q <= (wr_ptr_q == PTR_LAST) ? '0 : wr_ptr_q + 1'b1;
            end
            if (do_deq) begin
                rd_ptr_q <= (rd_ptr_q == PTR_LAST) ? '0 : rd_ptr_q + 1'b1;
            end
            case ({do_enq, do_deq})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;     // both or neither
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (do_enq) begin
            q_mem[wr_ptr_q] <= enq_entry_i;
        end
    end

endmodule : fetch_queue

//--- hdl/pc_gen.sv
`timescale 1ns/100ps
`include "fetch_cfg.svh"

module pc_gen
    import fetch_pkg::*;
(
    input  logic                clk,
    input  logic                rst,

    output logic                imem_req_o,
    output logic [`XLEN-1:0]    imem_addr_o,
    input  logic                imem_resp_i,
    input  logic [`XLEN-1:0]    imem_rdata_i,

    input  logic                redirect_i,
    input  logic [`XLEN-1:0]    redirect_pc_i,

    output logic [`XLEN-1:0]    btb_rd_pc_o,
    input  logic                btb_hit_i,
    input  logic [`XLEN-1:0]    btb_target_i,

    input  logic                fq_full_i,
    output logic                enq_o,
    output fetch_entry_t        enq_entry_o
);

    fetch_state_e       state_q, state_d;
    logic [`XLEN-1:0]   pc_q, pc_d;
    logic [`XLEN-1:0]   req_addr_q;     // pc of the outstanding request
    logic               fetch_en_q;     // low while in reset
    logic               resp_ok;
    logic [6:0]         opcode;
    logic               is_cti;
    logic               pred_taken;
    logic [`XLEN-1:0]   seq_pc;
    logic [`XLEN-1:0]   next_pc;

    // one request at a time, none while the queue is full
    assign imem_req_o  = fetch_en_q && (state_q == st_idle) && !fq_full_i && !redirect_i;
    assign imem_addr_o = pc_q;

    // redirect wins over a response in the same cycle
    assign resp_ok = (state_q == st_wait) && imem_resp_i && !redirect_i;

    // predecode of the returned word
    assign opcode = imem_rdata_i[6:0];
    assign is_cti = opcode inside {op_jal, op_jalr, op_br};

    // btb looked up with the pc the word belongs to
    assign btb_rd_pc_o = req_addr_q;
    assign pred_taken  = is_cti && btb_hit_i;
    assign seq_pc      = req_addr_q + `XLEN'(4);
    assign next_pc     = pred_taken ? btb_target_i : seq_pc;

    assign enq_o = resp_ok;

    always_comb begin
        enq_entry_o.inst        = imem_rdata_i;
        enq_entry_o.pc          = req_addr_q;
        enq_entry_o.pred_taken  = pred_taken;
        enq_entry_o.pred_target = next_pc;
    end

    always_comb begin
        state_d = state_q;
        pc_d    = pc_q;

        case (state_q)
            st_idle: begin
                if (imem_req_o) begin
                    state_d = st_wait;
                end
            end
            st_wait: begin
                if (imem_resp_i) begin
                    state_d = st_idle;
                    pc_d    = next_pc;     // btb target or pc + 4
                end
            end
            st_drop: begin
                if (imem_resp_i) begin
                    state_d = st_idle;     // stale word discarded
                end
            end
            default: begin
                state_d = st_idle;
            end
        endcase

        // back end redirect overrides the normal next pc
        if (redirect_i) begin
            pc_d = redirect_pc_i;
            if ((state_q != st_idle) && !imem_resp_i) begin
                state_d = st_drop;         // still waiting on memory
            end else begin
                state_d = st_idle;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q    <= st_idle;
            pc_q       <= `RESET_PC;
            fetch_en_q <= 1'b0;
        end else begin
            state_q    <= state_d;
            pc_q       <= pc_d;
            fetch_en_q <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (imem_req_o) begin
            req_addr_q <= pc_q;            // latched at issue
        end
    end

endmodule : pc_gen

//--- hdl/fetch_top.sv
`timescale 1ns/100ps
`include "fetch_cfg.svh"

module fetch_top
    import fetch_pkg::*;
(
    input  logic                clk,
    input  logic                rst,

    output logic                imem_req_o,
    output logic [`XLEN-1:0]    imem_addr_o,
    input  logic                imem_resp_i,
    input  logic [`XLEN-1:0]    imem_rdata_i,

    input  logic                redirect_i,
    input  logic [`XLEN-1:0]    redirect_pc_i,

    input  logic                btb_we_i,
    input  logic [`XLEN-1:0]    btb_pc_i,
    input  logic [`XLEN-1:0]    btb_target_i,

    input  logic                deq_i,
    output logic [`XLEN-1:0]    inst_o,
    output logic [`XLEN-1:0]    pc_o,
    output logic                pred_taken_o,
    output logic [`XLEN-1:0]    pred_target_o,
    output logic                empty_o
);

    logic [`XLEN-1:0]   btb_rd_pc;
    logic               btb_hit;
    logic [`XLEN-1:0]   btb_target;
    logic               fq_full;
    logic               enq;
    fetch_entry_t       enq_entry;
    fetch_entry_t       head_entry;

    pc_gen u_pc_gen (
        .clk            (clk),
        .rst            (rst),
        .imem_req_o     (imem_req_o),
        .imem_addr_o    (imem_addr_o),
        .imem_resp_i    (imem_resp_i),
        .imem_rdata_i   (imem_rdata_i),
        .redirect_i     (redirect_i),
        .redirect_pc_i  (redirect_pc_i),
        .btb_rd_pc_o    (btb_rd_pc),
        .btb_hit_i      (btb_hit),
        .btb_target_i   (btb_target),
        .fq_full_i      (fq_full),
        .enq_o          (enq),
        .enq_entry_o    (enq_entry)
    );

    btb u_btb (
        .clk            (clk),
        .rst            (rst),
        .rd_pc_i        (btb_rd_pc),
        .hit_o          (btb_hit),
        .target_o       (btb_target),
        .we_i           (btb_we_i),
        .wr_pc_i        (btb_pc_i),
        .wr_target_i    (btb_target_i)
    );

    fetch_queue u_fetch_queue (
        .clk            (clk),
        .rst            (rst),
        .flush_i        (redirect_i),     // redirect empties the queue
        .enq_i          (enq),
        .enq_entry_i    (enq_entry),
        .deq_i          (deq_i),
        .head_o         (head_entry),
        .full_o         (fq_full),
        .empty_o        (empty_o)
    );

    // queue head out to the back end
    assign inst_o        = head_entry.inst;
    assign pc_o          = head_entry.pc;
    assign pred_taken_o  = head_entry.pred_taken;
    assign pred_target_o = head_entry.pred_target;

endmodule : fetch_top

//--- dv/imem_model.sv
`timescale 1ns/100ps
`include "fetch_cfg.svh"

module imem_model (
    input  logic                clk,
    input  logic                rst,
    input  logic                req_i,
    input  logic [`XLEN-1:0]    addr_i,
    output logic                resp_o,
    output logic [`XLEN-1:0]    rdata_o,
    output logic                overlap_o   // sticky, second request before the answer
);

    localparam int MEM_WORDS = 256;         // indexed by addr[9:2]
    localparam int MAX_LAT   = 4;
    localparam int DRIVE_DLY = 10;

    logic [`XLEN-1:0]   mem [MEM_WORDS];    // filled by the testbench
    logic [`XLEN-1:0]   addr_q;
    logic               pending;
    int                 wait_cnt;

    initial begin
        resp_o    = 1'b0;
        rdata_o   = '0;
        overlap_o = 1'b0;
        pending   = 1'b0;
        wait_cnt  = 0;
        addr_q    = '0;
        forever begin
            @(posedge clk);
            #DRIVE_DLY;
            resp_o = 1'b0;                  // answer is a one-cycle pulse
            if (rst) begin
                pending = 1'b0;
            end else if (pending) begin
                if (wait_cnt <= 1) begin
                    resp_o  = 1'b1;
                    rdata_o = mem[addr_q[9:2]];
                    pending = 1'b0;
                end else begin
                    wait_cnt = wait_cnt - 1;
                end
            end

            // request seen mid cycle, answered 1 to MAX_LAT cycles later
            @(negedge clk);
            if (!rst && req_i) begin
                if (pending) begin
                    overlap_o = 1'b1;
                end
                pending  = 1'b1;
                addr_q   = addr_i;
                wait_cnt = $urandom_range(MAX_LAT, 1);
            end
        end
    end

endmodule : imem_model

//--- dv/tb_fetch_top.sv
`timescale 1ns/100ps
`include "fetch_cfg.svh"

module tb_fetch_top
    import fetch_pkg::*;
();

    localparam int CLK_PERIOD  = 100;
    localparam int DRIVE_DLY   = 10;
    localparam int MAX_LAT     = 4;
    localparam int RST_CYCLES  = 10;
    localparam int QUIET_CYC   = 10 * MAX_LAT;
    localparam int SEQ_LEN     = 12;
    localparam int DRAIN_LEN   = `FQ_DEPTH + 4;
    localparam int BTB_LEN     = 8;
    localparam int FLUSH_LEN   = 6;
    localparam int WAIT_LIMIT  = 64 * MAX_LAT;
    localparam int TEST_CYCLES = RST_CYCLES + QUIET_CYC + SEQ_LEN + DRAIN_LEN + BTB_LEN
                               + FLUSH_LEN + 2 * `FQ_DEPTH;
    localparam int WATCHDOG_CYC = TEST_CYCLES * 6 * MAX_LAT + 200;

    logic               clk;
    logic               rst;
    logic               imem_req;
    logic [`XLEN-1:0]   imem_addr;
    logic               imem_resp;
    logic [`XLEN-1:0]   imem_rdata;
    logic               redirect;
    logic [`XLEN-1:0]   redirect_pc;
    logic               btb_we;
    logic [`XLEN-1:0]   btb_pc;
    logic [`XLEN-1:0]   btb_target;
    logic               deq;
    logic [`XLEN-1:0]   inst;
    logic [`XLEN-1:0]   pc;
    logic               pred_taken;
    logic [`XLEN-1:0]   pred_target;
    logic               empty;
    logic               overlap;

    int                 errors = 0;
    int                 tests_run = 0;
    int                 tests_failed = 0;
    int                 cycle = 0;
    int                 req_count = 0;
    int                 last_req_cycle = 0;
    logic [`XLEN-1:0]   first_req_addr = '0;
    logic               outstanding = 1'b0;     // request still open past the next edge
    logic [`XLEN-1:0]   cap_pc[$];              // dequeued entries in order
    logic [`XLEN-1:0]   cap_inst[$];
    logic [`XLEN-1:0]   cap_target[$];
    logic               cap_taken[$];
    logic [(1<<`BTB_IDX_BITS)-1:0] btb_v = '0;  // expected btb contents
    logic [`XLEN-1:0]   btb_t [1<<`BTB_IDX_BITS];

    fetch_top u_fetch_top (
        .clk            (clk),
        .rst            (rst),
        .imem_req_o     (imem_req),
        .imem_addr_o    (imem_addr),
        .imem_resp_i    (imem_resp),
        .imem_rdata_i   (imem_rdata),
        .redirect_i     (redirect),
        .redirect_pc_i  (redirect_pc),
        .btb_we_i       (btb_we),
        .btb_pc_i       (btb_pc),
        .btb_target_i   (btb_target),
        .deq_i          (deq),
        .inst_o         (inst),
        .pc_o           (pc),
        .pred_taken_o   (pred_taken),
        .pred_target_o  (pred_target),
        .empty_o        (empty)
    );

    imem_model u_imem (
        .clk        (clk),
        .rst        (rst),
        .req_i      (imem_req),
        .addr_i     (imem_addr),
        .resp_o     (imem_resp),
        .rdata_o    (imem_rdata),
        .overlap_o  (overlap)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #(CLK_PERIOD / 2) clk = ~clk;
        end
    end

    initial begin
        repeat (WATCHDOG_CYC) @(posedge clk);
        $display("watchdog expired after %0d cycles, run stopped", WATCHDOG_CYC);
        $display(">>> FAIL");
        $finish;
    end

    // mid cycle sampling of requests and dequeued heads
    always @(negedge clk) begin
        cycle = cycle + 1;
        if (!rst && imem_req) begin
            if (req_count == 0) begin
                first_req_addr = imem_addr;
            end
            req_count      = req_count + 1;
            last_req_cycle = cycle;
            outstanding    = 1'b1;
        end else if (imem_resp) begin
            outstanding = 1'b0;
        end
        if (!rst && deq && !empty) begin
            cap_pc.push_back(pc);
            cap_inst.push_back(inst);
            cap_taken.push_back(pred_taken);
            cap_target.push_back(pred_target);
        end
    end

    task automatic next_drive();
        @(posedge clk);
        #DRIVE_DLY;
    endtask

    task automatic report_test(string name, int err0);
        tests_run++;
        if (errors != err0) begin
            tests_failed++;
            $display("test %s: %0d errors", name, errors - err0);
        end else begin
            $display("test %s: ok", name);
        end
    endtask

    task automatic wait_captured(int target, string name);
        int waited;
        waited = 0;
        while (cap_pc.size() < target && waited < WAIT_LIMIT) begin
            next_drive();
            waited++;
        end
        if (cap_pc.size() < target) begin
            $display("%s: timed out waiting for dequeued entry %0d", name, target);
            errors++;
        end
    endtask

    // expected pc chain takes the btb target on a cti hit and pc + 4 otherwise
    task automatic check_stream(string name, int base, logic [`XLEN-1:0] start_pc, int n);
        logic [`XLEN-1:0]           exp_pc;
        logic [`XLEN-1:0]           exp_inst;
        logic                       exp_taken;
        logic [`BTB_IDX_BITS-1:0]   bi;
        exp_pc = start_pc;
        for (int i = 0; i < n; i++) begin
            if (base + i >= cap_pc.size()) begin
                $display("%s: entry %0d never reached the queue head", name, i);
                errors++;
                return;
            end
            exp_inst  = u_imem.mem[exp_pc[9:2]];
            bi        = exp_pc[`BTB_IDX_BITS+1:2];
            exp_taken = btb_v[bi] && (exp_inst[6:0] inside {op_jal, op_jalr, op_br});
            if (cap_pc[base+i] !== exp_pc) begin
                $display("FAIL %s pc_o: expected %h, got %h", name, exp_pc, cap_pc[base+i]);
                errors++;
            end
            if (cap_inst[base+i] !== exp_inst) begin
                $display("FAIL %s inst_o: expected %h, got %h", name, exp_inst,
                         cap_inst[base+i]);
                errors++;
            end
            if (cap_taken[base+i] !== exp_taken) begin
                $display("FAIL %s pred_taken_o: expected %h, got %h", name, exp_taken,
                         cap_taken[base+i]);
                errors++;
            end
            if (exp_taken && cap_target[base+i] !== btb_t[bi]) begin
                $display("FAIL %s pred_target_o: expected %h, got %h", name, btb_t[bi],
                         cap_target[base+i]);
                errors++;
            end
            exp_pc = exp_taken ? btb_t[bi] : exp_pc + 32'd4;
        end
    endtask

    task automatic reset_check();
        int err0;
        int waited;
        err0 = errors;
        rst  = 1'b1;
        repeat (RST_CYCLES) begin
            @(negedge clk);
            if (empty !== 1'b1) begin
                $display("FAIL reset empty_o: expected %h, got %h", 1'b1, empty);
                errors++;
            end
            if (imem_req !== 1'b0) begin
                $display("FAIL reset imem_req_o: expected %h, got %h", 1'b0, imem_req);
                errors++;
            end
        end
        next_drive();
        rst = 1'b0;
        @(negedge clk);
        if (empty !== 1'b1) begin
            $display("FAIL reset empty_o: expected %h, got %h", 1'b1, empty);
            errors++;
        end
        waited = 0;
        while (req_count == 0 && waited < WAIT_LIMIT) begin
            next_drive();
            waited++;
        end
        if (req_count == 0) begin
            $display("reset: no fetch request came out after reset");
            errors++;
        end else if (first_req_addr !== `RESET_PC) begin
            $display("FAIL reset imem_addr_o: expected %h, got %h", `RESET_PC, first_req_addr);
            errors++;
        end
        report_test("reset", err0);
    endtask

    task automatic seq_check();
        int err0;
        err0 = errors;
        next_drive();
        deq = 1'b1;
        wait_captured(SEQ_LEN, "sequential");
        deq = 1'b0;
        check_stream("sequential", 0, `RESET_PC, SEQ_LEN);
        report_test("sequential", err0);
    endtask

    task automatic backpressure_check();
        int                 err0;
        int                 waited;
        int                 base;
        int                 queued;
        logic [`XLEN-1:0]   resume_pc;
        err0   = errors;
        waited = 0;
        while ((cycle - last_req_cycle) < QUIET_CYC && waited < WAIT_LIMIT) begin
            next_drive();
            waited++;
        end
        if ((cycle - last_req_cycle) < QUIET_CYC) begin
            $display("backpressure: fetch kept requesting with a full queue");
            errors++;
        end
        queued = req_count - cap_pc.size();     // answered but not dequeued
        if (queued != `FQ_DEPTH) begin
            $display("FAIL backpressure queue occupancy: expected %h, got %h",
                     `FQ_DEPTH, queued);
            errors++;
        end
        base      = cap_pc.size();
        resume_pc = `RESET_PC + 32'(base * 4);  // no redirect yet, straight line
        deq       = 1'b1;
        wait_captured(base + DRAIN_LEN, "backpressure");
        deq = 1'b0;
        check_stream("backpressure", base, resume_pc, DRAIN_LEN);
        report_test("backpressure", err0);
    endtask

    task automatic btb_check();
        int                 err0;
        int                 base;
        int                 taken_cnt;
        logic [`XLEN-1:0]   start_pc;
        logic [`XLEN-1:0]   br_pc;
        logic [`XLEN-1:0]   br_tgt;
        logic [`XLEN-1:0]   imm_pc;
        logic [`XLEN-1:0]   word;
        err0     = errors;
        start_pc = `RESET_PC + 32'h100;
        br_pc    = start_pc + 32'hc;
        br_tgt   = `RESET_PC + 32'h180;
        imm_pc   = br_tgt + 32'h4;                  // filler word that stays op_imm
        word     = u_imem.mem[br_pc[9:2]];
        u_imem.mem[br_pc[9:2]] = {word[31:7], op_br};

        next_drive();
        btb_we     = 1'b1;
        btb_pc     = br_pc;
        btb_target = br_tgt;
        btb_v[br_pc[`BTB_IDX_BITS+1:2]] = 1'b1;
        btb_t[br_pc[`BTB_IDX_BITS+1:2]] = br_tgt;
        next_drive();
        btb_pc     = imm_pc;
        btb_target = `RESET_PC + 32'h40;
        btb_v[imm_pc[`BTB_IDX_BITS+1:2]] = 1'b1;
        btb_t[imm_pc[`BTB_IDX_BITS+1:2]] = `RESET_PC + 32'h40;
        next_drive();
        btb_we      = 1'b0;
        redirect    = 1'b1;
        redirect_pc = start_pc;
        next_drive();
        redirect = 1'b0;
        base     = cap_pc.size();
        deq      = 1'b1;
        wait_captured(base + BTB_LEN, "btb");
        deq = 1'b0;
        check_stream("btb", base, start_pc, BTB_LEN);

        taken_cnt = 0;
        for (int i = base; i < cap_taken.size() && i < base + BTB_LEN; i++) begin
            taken_cnt += int'(cap_taken[i]);
        end
        if (taken_cnt != 1) begin
            $display("FAIL btb pred_taken_o count: expected %h, got %h", 1, taken_cnt);
            errors++;
        end
        report_test("btb", err0);
    endtask

    task automatic flush_check();
        int                 err0;
        int                 waited;
        int                 base;
        logic [`XLEN-1:0]   refill_pc;
        logic [`XLEN-1:0]   flush_pc;
        err0      = errors;
        refill_pc = `RESET_PC + 32'h200;
        flush_pc  = `RESET_PC + 32'h300;
        next_drive();
        redirect    = 1'b1;
        redirect_pc = refill_pc;
        next_drive();
        redirect = 1'b0;
        waited   = 0;
        while (!(outstanding && !empty) && waited < WAIT_LIMIT) begin
            next_drive();
            waited++;
        end
        if (!(outstanding && !empty)) begin
            $display("flush: never saw queued entries with a request in flight");
            errors++;
        end
        redirect    = 1'b1;
        redirect_pc = flush_pc;
        next_drive();
        redirect = 1'b0;
        @(negedge clk);
        if (empty !== 1'b1) begin
            $display("FAIL flush empty_o: expected %h, got %h", 1'b1, empty);
            errors++;
        end
        next_drive();
        base = cap_pc.size();
        deq  = 1'b1;
        wait_captured(base + FLUSH_LEN, "flush");
        deq = 1'b0;
        check_stream("flush", base, flush_pc, FLUSH_LEN);
        if (overlap !== 1'b0) begin
            $display("flush: memory got a second request before answering the first");
            errors++;
        end
        report_test("flush", err0);
    endtask

    initial begin
        logic [`XLEN-1:0] word;
        logic [`XLEN-1:0] addr;
        void'($urandom(32'h1214fb02));
        rst         = 1'b1;
        redirect    = 1'b0;
        redirect_pc = '0;
        btb_we      = 1'b0;
        btb_pc      = '0;
        btb_target  = '0;
        deq         = 1'b0;
        // filler alu words over the whole 1 KB window
        for (int i = 0; i < 256; i++) begin
            addr = `RESET_PC + 32'(i * 4);
            word = $urandom() ^ addr;
            u_imem.mem[addr[9:2]] = {word[31:7], op_imm};
        end

        reset_check();
        seq_check();
        backpressure_check();
        btb_check();
        flush_check();

        $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule : tb_fetch_top

//--- build.f
+incdir+hdl
hdl/fetch_pkg.sv
hdl/btb.sv
hdl/fetch_queue.sv
hdl/pc_gen.sv
hdl/fetch_top.sv
dv/imem_model.sv
dv/tb_fetch_top.sv

//--- run.sh
#!/usr/bin/env bash
# build and run the fetch front end testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --timescale 1ns/100ps \
    -f build.f --top-module tb_fetch_top -o sim_fetch

./obj_dir/sim_fetch | tee sim.log

if grep -qF '>>> FAIL' sim.log; then
    echo "simulation failed, see sim.log"
    exit 1
fi

if ! grep -qF '>>> PASS' sim.log; then
    echo "simulation ended without a verdict, see sim.log"
    exit 1
fi

echo "simulation passed"
